// File: common/sdr_cfg.svh
`ifndef SDR_CFG_SVH
`define SDR_CFG_SVH

// SDRAM timing, in sdram_clk_0 cycles
`define SDR_CAS_LATENCY 2
`define SDR_T_RCD 2
`define SDR_T_RP 2
`define SDR_T_RFC 7
// Write recovery plus auto-precharge
`define SDR_T_WR_AP 4

// Kept short for simulation
`define SDR_REFRESH_INTERVAL 390
`define SDR_INIT_WAIT 100

// SDRAM geometry
`define SDR_BA_W 2
`define SDR_ROW_W 13
`define SDR_COL_W 9
`define SDR_DQ_W 16

// Wishbone side
`define WB_DAT_W 32
`define WB_ADR_W 25

`endif

// File: common/sdr_pkg.sv
`include "sdr_cfg.svh"

package sdr_pkg;

   // Encoded as {ras_n, cas_n, we_n}
   typedef enum logic [2:0] {
      LOAD_MODE = 3'b000,
      REFRESH   = 3'b001,
      PRECHARGE = 3'b010,
      ACTIVE    = 3'b011,
      WRITE     = 3'b100,
      READ      = 3'b101,
      NOP       = 3'b111
   } sdr_cmd_e;

   // One Wishbone access, address already split
   typedef struct packed {
      logic                     we;
      logic [`SDR_BA_W-1:0]     ba;
      logic [`SDR_ROW_W-1:0]    row;
      // Word column, SDRAM column is {col, 1'b0}
      logic [`SDR_COL_W-2:0]    col;
      logic [`WB_DAT_W-1:0]     dat;
      logic [`WB_DAT_W/8-1:0]   sel;
   } wb_req_t;

   // Command and address pads
   typedef struct packed {
      logic                     cs_n;
      sdr_cmd_e                 cmd;
      logic [`SDR_BA_W-1:0]     ba;
      logic [`SDR_ROW_W-1:0]    a;
   } sdr_pad_t;

endpackage

// File: src/wb_req_capture.sv
`timescale 1ns/1ns
`include "sdr_cfg.svh"

module wb_req_capture (
   input  logic                     sdram_clk_0,
   input  logic                     wb_rst,
   input  logic                     wb_cyc_i,
   input  logic                     wb_stb_i,
   input  logic                     wb_we_i,
   input  logic [`WB_ADR_W-1:0]     wb_adr_i,
   input  logic [`WB_DAT_W-1:0]     wb_dat_i,
   input  logic [`WB_DAT_W/8-1:0]   wb_sel_i,
   input  logic [`WB_DAT_W-1:0]     rd_dat_i,
   input  logic                     done_i,
   output logic [`WB_DAT_W-1:0]     wb_dat_o,
   output logic                     wb_ack_o,
   output sdr_pkg::wb_req_t         req_o,
   output logic                     req_valid_o
);

   // Byte address layout {ba, row, col, byte}
   localparam int COL_LSB = $clog2(`WB_DAT_W / 8);
   localparam int ROW_LSB = COL_LSB + `SDR_COL_W - 1;
   localparam int BA_LSB  = ROW_LSB + `SDR_ROW_W;

   logic capture;

   // Master still holds stb during the ack cycle
   assign capture = wb_cyc_i && wb_stb_i && !req_valid_o && !wb_ack_o;

   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         req_valid_o <= 1'b0;
         wb_ack_o    <= 1'b0;
      end else begin
         wb_ack_o <= done_i;
         if (done_i) begin
            req_valid_o <= 1'b0;
         end else if (capture) begin
            req_valid_o <= 1'b1;
         end
      end
   end

   always_ff @(posedge sdram_clk_0) begin
      if (capture) begin
         req_o.we  <= wb_we_i;
         req_o.ba  <= wb_adr_i[BA_LSB +: `SDR_BA_W];
         req_o.row <= wb_adr_i[ROW_LSB +: `SDR_ROW_W];
         req_o.col <= wb_adr_i[COL_LSB +: `SDR_COL_W-1];
         req_o.dat <= wb_dat_i;
         req_o.sel <= wb_sel_i;
      end
   end

   // Read word held for the ack cycle
   always_ff @(posedge sdram_clk_0) begin
      if (done_i && !req_o.we) begin
         wb_dat_o <= rd_dat_i;
      end
   end

endmodule

// File: src/refresh_timer.sv
`timescale 1ns/1ns
`include "sdr_cfg.svh"

module refresh_timer (
   input  logic sdram_clk_0,
   input  logic wb_rst,
   input  logic init_done_i,
   input  logic ref_ack_i,
   output logic ref_req_o
);

   localparam int CNT_W = $clog2(`SDR_REFRESH_INTERVAL);

   logic [CNT_W-1:0] cnt;

   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         cnt       <= '0;
         ref_req_o <= 1'b0;
      end else if (ref_ack_i) begin
         cnt       <= '0;
         ref_req_o <= 1'b0;
      end else if (init_done_i && !ref_req_o) begin
         // Count parks at zero while a request is pending
         if (cnt == CNT_W'(`SDR_REFRESH_INTERVAL - 1)) begin
            cnt       <= '0;
            ref_req_o <= 1'b1;
         end else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

endmodule

// File: sdram/sdr_dq_path.sv
`timescale 1ns/1ns
`include "sdr_cfg.svh"

module sdr_dq_path (
   input  logic                     sdram_clk_0,
   input  logic                     wb_rst,
   input  logic                     wr_hi_i,
   input  logic                     rd_start_i,
   input  logic [`WB_DAT_W-1:0]     dat_i,
   input  logic [`WB_DAT_W/8-1:0]   sel_i,
   input  logic [`SDR_DQ_W-1:0]     dq_i,
   output logic [`SDR_DQ_W-1:0]     dq_o,
   output logic [1:0]               dqm_o,
   output logic                     dq_oe_o,
   output logic [`WB_DAT_W-1:0]     rd_dat_o,
   output logic                     rd_done_o
);

   // READ decision, pad cycle, then CAS latency, then the dq_i register
   localparam int RD_DLY = `SDR_CAS_LATENCY + 2;

   logic                   wr_lo;
   logic [RD_DLY-1:0]      rd_sr;
   logic                   rd_lo;
   logic [`SDR_DQ_W-1:0]   dq_i_q;

   // High half goes out with the WRITE command, low half one cycle later
   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         wr_lo   <= 1'b0;
         dq_oe_o <= 1'b0;
         dq_o    <= '0;
         dqm_o   <= '0;
      end else begin
         wr_lo   <= wr_hi_i;
         dq_oe_o <= wr_hi_i | wr_lo;
         if (wr_hi_i) begin
            dq_o  <= dat_i[`WB_DAT_W-1 -: `SDR_DQ_W];
            dqm_o <= ~sel_i[3:2];
         end else if (wr_lo) begin
            dq_o  <= dat_i[`SDR_DQ_W-1:0];
            dqm_o <= ~sel_i[1:0];
         end else begin
            dq_o  <= '0;
            dqm_o <= '0;
         end
      end
   end

   always_ff @(posedge sdram_clk_0) begin
      dq_i_q <= dq_i;
   end

   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         rd_sr     <= '0;
         rd_lo     <= 1'b0;
         rd_done_o <= 1'b0;
      end else begin
         rd_sr     <= {rd_sr[RD_DLY-2:0], rd_start_i};
         rd_lo     <= rd_sr[RD_DLY-1];
         rd_done_o <= rd_lo;
      end
   end

   always_ff @(posedge sdram_clk_0) begin
      if (rd_sr[RD_DLY-1]) begin
         rd_dat_o[`WB_DAT_W-1 -: `SDR_DQ_W] <= dq_i_q;
      end
      if (rd_lo) begin
         rd_dat_o[`SDR_DQ_W-1:0] <= dq_i_q;
      end
   end

endmodule

// File: sdram/sdr_cmd_fsm.sv
`timescale 1ns/1ns
`include "sdr_cfg.svh"

module sdr_cmd_fsm (
   input  logic                     sdram_clk_0,
   input  logic                     wb_rst,
   input  sdr_pkg::wb_req_t         req_i,
   input  logic                     req_valid_i,
   input  logic                     ref_req_i,
   input  logic [`SDR_DQ_W-1:0]     dq_i,
   output logic                     done_o,
   output logic                     ref_ack_o,
   output logic                     init_done_o,
   output logic [`WB_DAT_W-1:0]     rd_dat_o,
   output sdr_pkg::sdr_pad_t        sdram_pad_o,
   output logic [1:0]               dqm_o,
   output logic [`SDR_DQ_W-1:0]     dq_o,
   output logic                     dq_oe_o,
   output logic                     cke_o
);
   import sdr_pkg::*;

   localparam int CNT_W = $clog2(`SDR_INIT_WAIT);
   // Burst length 2, sequential, CAS latency
   localparam logic [`SDR_ROW_W-1:0] MODE_REG = `SDR_ROW_W'((`SDR_CAS_LATENCY << 4) | 1);
   localparam int AP_BIT = 10;

   typedef enum logic [3:0] {
      S_INIT_WAIT, S_INIT_PRE, S_INIT_REF1, S_INIT_REF2,
      S_WAIT, S_IDLE, S_ACT, S_WR, S_RD
   } state_t;

   state_t                 state, state_nxt;
   logic [CNT_W-1:0]       cnt, cnt_nxt;
   sdr_pad_t               pad_nxt;
   logic                   init_nxt;
   logic [`SDR_ROW_W-1:0]  col_addr;
   logic                   wr_hi;
   logic                   rd_start;
   logic                   rd_done;

   always_comb begin
      col_addr = '0;
      col_addr[AP_BIT] = 1'b1;
      col_addr[`SDR_COL_W-1:0] = {req_i.col, 1'b0};
   end

   always_comb begin
      state_nxt    = state;
      cnt_nxt      = (cnt != '0) ? cnt - 1'b1 : cnt;
      pad_nxt.cs_n = 1'b0;
      pad_nxt.cmd  = NOP;
      pad_nxt.ba   = '0;
      pad_nxt.a    = '0;
      init_nxt     = init_done_o;
      wr_hi        = 1'b0;
      rd_start     = 1'b0;
      done_o       = 1'b0;
      ref_ack_o    = 1'b0;
      case (state)
         S_INIT_WAIT: if (cnt == '0) begin
            // Precharge all banks
            pad_nxt.cmd       = PRECHARGE;
            pad_nxt.a[AP_BIT] = 1'b1;
            cnt_nxt           = CNT_W'(`SDR_T_RP - 1);
            state_nxt         = S_INIT_PRE;
         end
         S_INIT_PRE: if (cnt == '0) begin
            pad_nxt.cmd = REFRESH;
            cnt_nxt     = CNT_W'(`SDR_T_RFC - 1);
            state_nxt   = S_INIT_REF1;
         end
         S_INIT_REF1: if (cnt == '0) begin
            pad_nxt.cmd = REFRESH;
            cnt_nxt     = CNT_W'(`SDR_T_RFC - 1);
            state_nxt   = S_INIT_REF2;
         end
         S_INIT_REF2: if (cnt == '0) begin
            pad_nxt.cmd = LOAD_MODE;
            pad_nxt.a   = MODE_REG;
            // tMRD fits inside tRP
            cnt_nxt     = CNT_W'(`SDR_T_RP - 1);
            init_nxt    = 1'b1;
            state_nxt   = S_WAIT;
         end
         S_WAIT: if (cnt == '0) begin
            state_nxt = S_IDLE;
         end
         S_IDLE: begin
            if (ref_req_i) begin
               pad_nxt.cmd = REFRESH;
               ref_ack_o   = 1'b1;
               cnt_nxt     = CNT_W'(`SDR_T_RFC - 1);
               state_nxt   = S_WAIT;
            end else if (req_valid_i) begin
               pad_nxt.cmd = ACTIVE;
               pad_nxt.ba  = req_i.ba;
               pad_nxt.a   = req_i.row;
               cnt_nxt     = CNT_W'(`SDR_T_RCD - 1);
               state_nxt   = S_ACT;
            end
         end
         S_ACT: if (cnt == '0) begin
            pad_nxt.ba = req_i.ba;
            pad_nxt.a  = col_addr;
            if (req_i.we) begin
               pad_nxt.cmd = WRITE;
               wr_hi       = 1'b1;
               cnt_nxt     = CNT_W'(`SDR_T_WR_AP - 1);
               state_nxt   = S_WR;
            end else begin
               pad_nxt.cmd = READ;
               rd_start    = 1'b1;
               state_nxt   = S_RD;
            end
         end
         S_WR: if (cnt == '0) begin
            done_o    = 1'b1;
            state_nxt = S_IDLE;
         end
         S_RD: if (rd_done) begin
            done_o    = 1'b1;
            state_nxt = S_IDLE;
         end
         default: state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         state            <= S_INIT_WAIT;
         cnt              <= CNT_W'(`SDR_INIT_WAIT - 1);
         init_done_o      <= 1'b0;
         sdram_pad_o.cs_n <= 1'b0;
         sdram_pad_o.cmd  <= NOP;
         sdram_pad_o.ba   <= '0;
         sdram_pad_o.a    <= '0;
      end else begin
         state       <= state_nxt;
         cnt         <= cnt_nxt;
         init_done_o <= init_nxt;
         sdram_pad_o <= pad_nxt;
      end
   end

   assign cke_o = 1'b1;

   sdr_dq_path sdr_dq_path_i (
      .sdram_clk_0 (sdram_clk_0),
      .wb_rst      (wb_rst),
      .wr_hi_i     (wr_hi),
      .rd_start_i  (rd_start),
      .dat_i       (req_i.dat),
      .sel_i       (req_i.sel),
      .dq_i        (dq_i),
      .dq_o        (dq_o),
      .dqm_o       (dqm_o),
      .dq_oe_o     (dq_oe_o),
      .rd_dat_o    (rd_dat_o),
      .rd_done_o   (rd_done)
   );

endmodule

// File: src/sdr_ctrl_top.sv
`timescale 1ns/1ns
`include "sdr_cfg.svh"

module sdr_ctrl_top (
   input  logic                     sdram_clk_0,
   input  logic                     wb_rst,
   input  logic                     wb_cyc_i,
   input  logic                     wb_stb_i,
   input  logic                     wb_we_i,
   input  logic [`WB_ADR_W-1:0]     wb_adr_i,
   input  logic [`WB_DAT_W-1:0]     wb_dat_i,
   input  logic [`WB_DAT_W/8-1:0]   wb_sel_i,
   output logic [`WB_DAT_W-1:0]     wb_dat_o,
   output logic                     wb_ack_o,
   output sdr_pkg::sdr_pad_t        sdram_pad_o,
   output logic [1:0]               dqm_o,
   output logic [`SDR_DQ_W-1:0]     dq_o,
   output logic                     dq_oe_o,
   input  logic [`SDR_DQ_W-1:0]     dq_i,
   output logic                     cke_o
);
   import sdr_pkg::*;

   wb_req_t                req;
   logic                   req_valid;
   logic                   done;
   logic                   ref_req;
   logic                   ref_ack;
   logic                   init_done;
   logic [`WB_DAT_W-1:0]   rd_dat;

   wb_req_capture wb_req_capture_i (
      .sdram_clk_0 (sdram_clk_0),
      .wb_rst      (wb_rst),
      .wb_cyc_i    (wb_cyc_i),
      .wb_stb_i    (wb_stb_i),
      .wb_we_i     (wb_we_i),
      .wb_adr_i    (wb_adr_i),
      .wb_dat_i    (wb_dat_i),
      .wb_sel_i    (wb_sel_i),
      .rd_dat_i    (rd_dat),
      .done_i      (done),
      .wb_dat_o    (wb_dat_o),
      .wb_ack_o    (wb_ack_o),
      .req_o       (req),
      .req_valid_o (req_valid)
   );

   refresh_timer refresh_timer_i (
      .sdram_clk_0 (sdram_clk_0),
      .wb_rst      (wb_rst),
      .init_done_i (init_done),
      .ref_ack_i   (ref_ack),
      .ref_req_o   (ref_req)
   );

   sdr_cmd_fsm sdr_cmd_fsm_i (
      .sdram_clk_0 (sdram_clk_0),
      .wb_rst      (wb_rst),
      .req_i       (req),
      .req_valid_i (req_valid),
      .ref_req_i   (ref_req),
      .dq_i        (dq_i),
      .done_o      (done),
      .ref_ack_o   (ref_ack),
      .init_done_o (init_done),
      .rd_dat_o    (rd_dat),
      .sdram_pad_o (sdram_pad_o),
      .dqm_o       (dqm_o),
      .dq_o        (dq_o),
      .dq_oe_o     (dq_oe_o),
      .cke_o       (cke_o)
   );

endmodule

// File: test/sdram_model.sv
`timescale 1ns/1ns
`include "sdr_cfg.svh"

module sdram_model (
   input  logic                     sdram_clk_0,
   input  logic                     rst_i,
   input  sdr_pkg::sdr_pad_t        pad_i,
   input  logic [1:0]               dqm_i,
   input  logic [`SDR_DQ_W-1:0]     dq_i,
   input  logic                     dq_oe_i,
   output logic [`SDR_DQ_W-1:0]     dq_o,
   output int                       err_cnt_o,
   output int                       ref_cnt_o,
   output int                       init_step_o,
   output logic [`SDR_ROW_W-1:0]    mode_o
);
   import sdr_pkg::*;

   // Word address {ba, row, col}
   localparam int AW = `SDR_BA_W + `SDR_ROW_W + `SDR_COL_W;
   localparam int NB = 2 ** `SDR_BA_W;

   logic [`SDR_DQ_W-1:0]   mem [logic [AW-1:0]];
   logic [`SDR_ROW_W-1:0]  open_row [NB];
   logic [NB-1:0]          row_open;
   logic                   wr_pend;
   logic [AW-1:0]          wr_addr;
   logic [AW-1:0]          rd_addr;
   logic [AW-1:0]          cmd_addr;
   int                     rd_wait;

   assign cmd_addr = {pad_i.ba, open_row[pad_i.ba], pad_i.a[`SDR_COL_W-1:0]};

   task automatic flag(input string what);
      $display("sdram_model: %s at %0t ns", what, $time);
      err_cnt_o++;
   endtask

   // Byte lanes masked by DQM, bit 1 for the upper byte
   task automatic store(input logic [AW-1:0] addr, input logic [`SDR_DQ_W-1:0] d);
      logic [`SDR_DQ_W-1:0] w;
      w = mem.exists(addr) ? mem[addr] : '0;
      if (!dq_oe_i) begin
         flag("write data taken while the controller was not driving DQ");
      end
      if (!dqm_i[1]) begin
         w[15:8] = d[15:8];
      end
      if (!dqm_i[0]) begin
         w[7:0] = d[7:0];
      end
      mem[addr] = w;
   endtask

   function automatic logic [`SDR_DQ_W-1:0] fetch(input logic [AW-1:0] addr);
      return mem.exists(addr) ? mem[addr] : '0;
   endfunction

   always @(posedge sdram_clk_0 or posedge rst_i) begin
      if (rst_i) begin
         row_open    <= '0;
         wr_pend     <= 1'b0;
         rd_wait     <= 0;
         dq_o        <= '0;
         err_cnt_o    = 0;
         ref_cnt_o   <= 0;
         init_step_o <= 0;
         mode_o      <= '0;
      end else begin
         // Second beat of a write burst
         wr_pend <= 1'b0;
         if (wr_pend) begin
            store(wr_addr + 1'b1, dq_i);
         end
         // Data changes after this edge, so it is sampled CAS latency edges after READ
         if (rd_wait == 2) begin
            dq_o <= fetch(rd_addr);
         end else if (rd_wait == 1) begin
            dq_o <= fetch(rd_addr + 1'b1);
         end else begin
            dq_o <= '0;
         end
         if (rd_wait != 0) begin
            rd_wait <= rd_wait - 1;
         end
         if (!pad_i.cs_n) begin
            case (pad_i.cmd)
               ACTIVE: begin
                  if (init_step_o != 4) begin
                     flag("ACTIVE before initialisation completed");
                  end
                  if (row_open[pad_i.ba]) begin
                     flag("ACTIVE to a bank that already has an open row");
                  end
                  row_open[pad_i.ba] <= 1'b1;
                  open_row[pad_i.ba] <= pad_i.a;
               end
               READ, WRITE: begin
                  if (init_step_o != 4) begin
                     flag("READ or WRITE before LOAD_MODE");
                  end
                  if (!row_open[pad_i.ba]) begin
                     flag("READ or WRITE to a bank with no open row");
                  end
                  // Auto-precharge
                  if (pad_i.a[10]) begin
                     row_open[pad_i.ba] <= 1'b0;
                  end
                  if (pad_i.cmd == WRITE) begin
                     store(cmd_addr, dq_i);
                     wr_addr <= cmd_addr;
                     wr_pend <= 1'b1;
                  end else begin
                     rd_addr <= cmd_addr;
                     rd_wait <= int'(mode_o[6:4]);
                  end
               end
               PRECHARGE: begin
                  if (pad_i.a[10]) begin
                     row_open <= '0;
                  end else begin
                     row_open[pad_i.ba] <= 1'b0;
                  end
                  if (init_step_o == 0 && pad_i.a[10]) begin
                     init_step_o <= 1;
                  end else if (init_step_o != 4) begin
                     flag("PRECHARGE out of order during initialisation");
                  end
               end
               REFRESH: begin
                  if (row_open != '0) begin
                     flag("REFRESH while a row is open");
                  end
                  ref_cnt_o <= ref_cnt_o + 1;
                  if (init_step_o == 1 || init_step_o == 2) begin
                     init_step_o <= init_step_o + 1;
                  end else if (init_step_o != 4) begin
                     flag("REFRESH out of order during initialisation");
                  end
               end
               LOAD_MODE: begin
                  if (init_step_o != 3) begin
                     flag("LOAD_MODE out of order during initialisation");
                  end
                  mode_o      <= pad_i.a;
                  init_step_o <= 4;
               end
               default: begin
               end
            endcase
         end
      end
   end

endmodule

// File: test/sdr_ctrl_assert.sv
`timescale 1ns/1ns

module sdr_ctrl_assert (
   input logic              sdram_clk_0,
   input logic              wb_rst,
   input logic              wb_cyc_i,
   input logic              wb_stb_i,
   input logic              wb_ack_o,
   input sdr_pkg::sdr_pad_t sdram_pad_o,
   input logic              dq_oe_o
);
   import sdr_pkg::*;

   ack_in_cycle: assert property (@(posedge sdram_clk_0) disable iff (wb_rst)
      wb_ack_o |-> (wb_cyc_i && wb_stb_i))
      else $error("wb_ack_o high outside a Wishbone cycle");

   ack_one_cycle: assert property (@(posedge sdram_clk_0) disable iff (wb_rst)
      wb_ack_o |=> !wb_ack_o)
      else $error("wb_ack_o held for more than one cycle");

   // High half of the write burst goes out with the WRITE command
   oe_with_write: assert property (@(posedge sdram_clk_0) disable iff (wb_rst)
      $rose(dq_oe_o) |-> (!sdram_pad_o.cs_n && sdram_pad_o.cmd == WRITE))
      else $error("dq_oe_o rose without a WRITE command on the pads");

   // Write burst releases DQ after two cycles
   oe_max_two: assert property (@(posedge sdram_clk_0) disable iff (wb_rst)
      (dq_oe_o && $past(dq_oe_o)) |=> !dq_oe_o)
      else $error("dq_oe_o high for more than two cycles");

endmodule

bind sdr_ctrl_top sdr_ctrl_assert sdr_ctrl_assert_i (
   .sdram_clk_0 (sdram_clk_0),
   .wb_rst      (wb_rst),
   .wb_cyc_i    (wb_cyc_i),
   .wb_stb_i    (wb_stb_i),
   .wb_ack_o    (wb_ack_o),
   .sdram_pad_o (sdram_pad_o),
   .dq_oe_o     (dq_oe_o)
);

// File: test/tb_sdr_ctrl.sv
`timescale 1ns/1ns
`include "sdr_cfg.svh"

module tb_sdr_ctrl;
   import sdr_pkg::*;

   localparam int ACK_TIMEOUT  = 400;
   localparam int INIT_TIMEOUT = 1000;
   localparam int RND_COUNT    = 20;

   typedef struct packed {
      logic                   we;
      logic [`WB_ADR_W-1:0]   adr;
      logic [`WB_DAT_W-1:0]   dat;
      logic [3:0]             sel;
      logic [`WB_DAT_W-1:0]   exp;
   } vec_t;

   logic                   sdram_clk_0;
   logic                   wb_rst;
   logic                   wb_cyc_i;
   logic                   wb_stb_i;
   logic                   wb_we_i;
   logic [`WB_ADR_W-1:0]   wb_adr_i;
   logic [`WB_DAT_W-1:0]   wb_dat_i;
   logic [3:0]             wb_sel_i;
   logic [`WB_DAT_W-1:0]   wb_dat_o;
   logic                   wb_ack_o;
   sdr_pad_t               sdram_pad;
   logic [1:0]             dqm;
   logic [`SDR_DQ_W-1:0]   dq_out;
   logic [`SDR_DQ_W-1:0]   dq_in;
   logic                   dq_oe;
   logic                   cke;
   int                     model_errs;
   int                     model_refs;
   int                     init_step;
   logic [`SDR_ROW_W-1:0]  mode_reg;

   vec_t                   vecs[$];
   string                  names[$];
   logic [`WB_DAT_W-1:0]   ref_mem [logic [`WB_ADR_W-1:0]];
   logic [`WB_ADR_W-1:0]   rnd_adr [RND_COUNT];
   int                     errors;
   int                     err_mark;
   int                     tests;

   sdr_ctrl_top sdr_ctrl_top_i (
      .sdram_clk_0 (sdram_clk_0),
      .wb_rst      (wb_rst),
      .wb_cyc_i    (wb_cyc_i),
      .wb_stb_i    (wb_stb_i),
      .wb_we_i     (wb_we_i),
      .wb_adr_i    (wb_adr_i),
      .wb_dat_i    (wb_dat_i),
      .wb_sel_i    (wb_sel_i),
      .wb_dat_o    (wb_dat_o),
      .wb_ack_o    (wb_ack_o),
      .sdram_pad_o (sdram_pad),
      .dqm_o       (dqm),
      .dq_o        (dq_out),
      .dq_oe_o     (dq_oe),
      .dq_i        (dq_in),
      .cke_o       (cke)
   );

   sdram_model sdram_model_i (
      .sdram_clk_0 (sdram_clk_0),
      .rst_i       (wb_rst),
      .pad_i       (sdram_pad),
      .dqm_i       (dqm),
      .dq_i        (dq_out),
      .dq_oe_i     (dq_oe),
      .dq_o        (dq_in),
      .err_cnt_o   (model_errs),
      .ref_cnt_o   (model_refs),
      .init_step_o (init_step),
      .mode_o      (mode_reg)
   );

   always #20 sdram_clk_0 = ~sdram_clk_0;

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      $display("%-28s %s", name, (errors == err_mark) ? "ok" : "error");
      tests++;
      err_mark = errors;
   endtask

   task automatic abort_run(input string what);
      $display("Timeout: %s", what);
      $display("Simulation FAILED");
      $finish;
   endtask

   // Classic cycle, held until ack
   task automatic wb_access(input logic we, input logic [`WB_ADR_W-1:0] adr,
                            input logic [31:0] dat, input logic [3:0] sel,
                            output logic [31:0] rdat);
      int waited;
      @(posedge sdram_clk_0);
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      wb_we_i  <= we;
      wb_adr_i <= adr;
      wb_dat_i <= dat;
      wb_sel_i <= sel;
      waited = 0;
      @(posedge sdram_clk_0);
      while (!wb_ack_o && waited < ACK_TIMEOUT) begin
         @(posedge sdram_clk_0);
         waited++;
      end
      if (!wb_ack_o) begin
         abort_run($sformatf("no wb_ack_o for address %h", adr));
      end
      rdat = wb_dat_o;
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
   endtask

   task automatic add_vec(input string name, input logic we, input logic [`WB_ADR_W-1:0] adr,
                          input logic [31:0] dat, input logic [3:0] sel, input logic [31:0] exp);
      vecs.push_back({we, adr, dat, sel, exp});
      names.push_back(name);
   endtask

   // Address fields: ba 24:23, row 22:10, word column 9:2
   task automatic load_table();
      add_vec("wr_base",      1'b1, 25'h0000000, 32'hDEADBEEF, 4'hF, 32'h0);
      add_vec("wr_next_col",  1'b1, 25'h0000004, 32'hCAFEF00D, 4'hF, 32'h0);
      add_vec("wr_bank3",     1'b1, 25'h1800010, 32'h13579BDF, 4'hF, 32'h0);
      add_vec("wr_row_4b",    1'b1, 25'h0012C08, 32'h2468ACE0, 4'hF, 32'h0);
      add_vec("wr_last_col",  1'b1, 25'h00003FC, 32'h0F1E2D3C, 4'hF, 32'h0);
      add_vec("wr_bank1",     1'b1, 25'h0800000, 32'h11111111, 4'hF, 32'h0);
      add_vec("wr_row1",      1'b1, 25'h0000400, 32'h22222222, 4'hF, 32'h0);
      add_vec("wr_bytes_all", 1'b1, 25'h0000100, 32'hFFFFFFFF, 4'hF, 32'h0);
      add_vec("wr_bytes_0_2", 1'b1, 25'h0000100, 32'h12345678, 4'b0101, 32'h0);
      add_vec("rd_base",      1'b0, 25'h0000000, 32'h0, 4'hF, 32'hDEADBEEF);
      add_vec("rd_next_col",  1'b0, 25'h0000004, 32'h0, 4'hF, 32'hCAFEF00D);
      add_vec("rd_bank3",     1'b0, 25'h1800010, 32'h0, 4'hF, 32'h13579BDF);
      add_vec("rd_row_4b",    1'b0, 25'h0012C08, 32'h0, 4'hF, 32'h2468ACE0);
      add_vec("rd_last_col",  1'b0, 25'h00003FC, 32'h0, 4'hF, 32'h0F1E2D3C);
      add_vec("rd_bank1",     1'b0, 25'h0800000, 32'h0, 4'hF, 32'h11111111);
      add_vec("rd_row1",      1'b0, 25'h0000400, 32'h0, 4'hF, 32'h22222222);
      add_vec("rd_bytes",     1'b0, 25'h0000100, 32'h0, 4'hF, 32'hFF34FF78);
   endtask

   task automatic run_vec(input int i);
      logic [31:0] rdat;
      wb_access(vecs[i].we, vecs[i].adr, vecs[i].dat, vecs[i].sel, rdat);
      if (!vecs[i].we) begin
         check(names[i], vecs[i].exp, rdat);
      end
      end_test(names[i]);
   endtask

   task automatic wait_init();
      int waited;
      waited = 0;
      while (init_step != 4 && waited < INIT_TIMEOUT) begin
         @(posedge sdram_clk_0);
         waited++;
      end
      if (init_step != 4) begin
         abort_run("SDRAM initialisation sequence never completed");
      end
      check("init_mode_register", 32'h021, 32'(mode_reg));
      check("init_refresh_count", 32'd2, 32'(model_refs));
      check("init_cke", 32'd1, 32'(cke));
      end_test("init_sequence");
   endtask

   task automatic idle_refresh();
      int seen;
      seen = 0;
      repeat (4 * `SDR_REFRESH_INTERVAL) begin
         @(posedge sdram_clk_0);
         if (!sdram_pad.cs_n && sdram_pad.cmd == REFRESH) begin
            seen++;
         end
      end
      check("refresh_in_range", 32'd1, 32'(seen >= 3 && seen <= 5));
      end_test($sformatf("idle_refresh (%0d seen)", seen));
   endtask

   task automatic random_traffic();
      logic [`WB_ADR_W-1:0]   adr;
      logic [31:0]            dat;
      logic [31:0]            rdat;
      for (int i = 0; i < RND_COUNT; i++) begin
         adr = `WB_ADR_W'($urandom()) & 25'h1FFFFFC;
         dat = $urandom();
         wb_access(1'b1, adr, dat, 4'hF, rdat);
         ref_mem[adr] = dat;
         rnd_adr[i] = adr;
      end
      for (int i = 0; i < RND_COUNT; i++) begin
         wb_access(1'b0, rnd_adr[i], 32'h0, 4'hF, rdat);
         check($sformatf("random_read_%0d", i), ref_mem[rnd_adr[i]], rdat);
      end
      end_test("random_traffic");
   endtask

   initial begin
      int unsigned seed;
      sdram_clk_0 = 1'b0;
      wb_rst      = 1'b1;
      wb_cyc_i    = 1'b0;
      wb_stb_i    = 1'b0;
      wb_we_i     = 1'b0;
      wb_adr_i    = '0;
      wb_dat_i    = '0;
      wb_sel_i    = '0;
      errors      = 0;
      err_mark    = 0;
      tests       = 0;
      seed        = $urandom(32'h3051632f);
      repeat (2) @(posedge sdram_clk_0);
      wb_rst <= 1'b0;
      @(posedge sdram_clk_0);
      check("reset_ack", 32'd0, 32'(wb_ack_o));
      check("reset_dq_oe", 32'd0, 32'(dq_oe));
      check("reset_cke", 32'd1, 32'(cke));
      check("reset_pad_cmd", 32'(NOP), 32'(sdram_pad.cmd));
      check("reset_pad_cs_n", 32'd0, 32'(sdram_pad.cs_n));
      end_test("reset_state");
      wait_init();
      load_table();
      for (int i = 0; i < vecs.size(); i++) begin
         run_vec(i);
      end
      idle_refresh();
      random_traffic();
      check("model_protocol_errors", 32'd0, 32'(model_errs));
      end_test("sdram_protocol");
      $display("%0d tests, %0d errors", tests, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: tb.f
+incdir+common
common/sdr_pkg.sv
src/wb_req_capture.sv
src/refresh_timer.sv
sdram/sdr_dq_path.sv
sdram/sdr_cmd_fsm.sv
src/sdr_ctrl_top.sv
test/sdram_model.sv
test/sdr_ctrl_assert.sv
test/tb_sdr_ctrl.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/1ns -f tb.f --top-module tb_sdr_ctrl
	@out="$$(./obj_dir/Vtb_sdr_ctrl)"; echo "$$out"; echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir
